// File: Bender.yml
package:
  name: rsmp

sources:
  - files:
      - design/rsmp_pkg.sv
      - design/rsmp_ring_buffer.sv
      - design/rsmp_coef_rom.sv
      - design/rsmp_mac_core.sv
      - design/rsmp_wb_result.sv
      - design/rsmp_top.sv
  - target: simulation
    files:
      - dv/rsmp_properties.sv
      - dv/rsmp_tb.sv

// File: all.f
design/rsmp_pkg.sv
design/rsmp_ring_buffer.sv
design/rsmp_coef_rom.sv
design/rsmp_mac_core.sv
design/rsmp_wb_result.sv
design/rsmp_top.sv
dv/rsmp_properties.sv
dv/rsmp_tb.sv

// File: design/rsmp_coef_rom.sv
`timescale 1ns/1ps
`default_nettype none

module rsmp_coef_rom (
    input  wire                    clk,
    input  wire rsmp_pkg::phase_t  phase_i,
    input  wire rsmp_pkg::tap_t    tap_i,
    output rsmp_pkg::coef_t        coef_o
);

    // One row of HALF_DEPTH taps per phase
    rsmp_pkg::coef_t coef_tab [rsmp_pkg::NUM_PHASE*rsmp_pkg::HALF_DEPTH];

    for (genvar p = 0; p < rsmp_pkg::NUM_PHASE; p++) begin : g_phase
        for (genvar j = 0; j < rsmp_pkg::HALF_DEPTH; j++) begin : g_tap
            assign coef_tab[p*rsmp_pkg::HALF_DEPTH + j] = rsmp_pkg::coef_value(p, j);
        end
    end

    always_ff @(posedge clk) begin
        coef_o <= coef_tab[{phase_i, tap_i}];  // Row major, phase then tap
    end

endmodule

`default_nettype wire

// File: design/rsmp_mac_core.sv
`timescale 1ns/1ps
`default_nettype none

module rsmp_mac_core (
    input  wire                     clk,
    input  wire                     rst,
    input  wire rsmp_pkg::count_t   count_i,
    output logic                    pop_o,
    output rsmp_pkg::offset_t       offset_o,
    input  wire rsmp_pkg::sample_t  rd_data_i,
    output rsmp_pkg::phase_t        phase_o,
    output rsmp_pkg::tap_t          tap_o,
    input  wire rsmp_pkg::coef_t    coef_i,
    input  wire                     result_full_i,
    output logic                    result_push_o,
    output rsmp_pkg::result_t       result_o
);

    rsmp_pkg::mac_state_e state_q;
    rsmp_pkg::phase_t     phase_q;
    rsmp_pkg::result_t    sum_q;
    logic [2:0]           wing_cnt;   // Cycle within a wing
    logic [$bits(rsmp_pkg::phase_t):0] phase_sum;
    logic                 wrap;
    logic                 wing_last;
    logic                 in_lwing;
    logic                 product_valid;
    logic                 start;

    // Multiplier stages, signed sample times unsigned coefficient
    logic signed [rsmp_pkg::SAMPLE_W+rsmp_pkg::COEF_W:0] prod_pipe [rsmp_pkg::MULT_LATENCY];

    assign phase_sum = {1'b0, phase_q} + ($bits(rsmp_pkg::phase_t)+1)'(rsmp_pkg::PHASE_STEP);
    assign wrap      = (phase_sum >= ($bits(rsmp_pkg::phase_t)+1)'(rsmp_pkg::NUM_PHASE));
    assign wing_last = (wing_cnt == 3'(rsmp_pkg::HALF_DEPTH + rsmp_pkg::MULT_LATENCY));
    assign in_lwing  = (state_q == rsmp_pkg::ST_LWING);
    assign start     = (count_i >= rsmp_pkg::count_t'(2*rsmp_pkg::HALF_DEPTH)) && !result_full_i;

    // First product of a wing leaves the pipe MULT_LATENCY+1 cycles after its address
    assign product_valid = (state_q == rsmp_pkg::ST_RWING || in_lwing) &&
                           (wing_cnt > 3'(rsmp_pkg::MULT_LATENCY));

    // Tap and window addressing
    assign tap_o   = rsmp_pkg::tap_t'(wing_cnt);
    assign phase_o = in_lwing ? rsmp_pkg::phase_t'(rsmp_pkg::NUM_PHASE - 1) - phase_q
                              : phase_q;
    assign offset_o = in_lwing
        ? rsmp_pkg::offset_t'(rsmp_pkg::HALF_DEPTH - 1) - rsmp_pkg::offset_t'(tap_o)  // Walks back
        : rsmp_pkg::offset_t'(rsmp_pkg::HALF_DEPTH) + rsmp_pkg::offset_t'(tap_o);

    assign result_push_o = (state_q == rsmp_pkg::ST_END);
    assign pop_o         = (state_q == rsmp_pkg::ST_END) && wrap;
    assign result_o      = sum_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= rsmp_pkg::ST_READY;
            phase_q  <= '0;
            wing_cnt <= '0;
        end else begin
            case (state_q)
                rsmp_pkg::ST_READY: begin
                    if (start) begin
                        state_q <= rsmp_pkg::ST_BEGIN;
                    end
                end
                rsmp_pkg::ST_BEGIN: begin
                    wing_cnt <= '0;
                    state_q  <= rsmp_pkg::ST_RWING;
                end
                rsmp_pkg::ST_RWING: begin
                    wing_cnt <= wing_cnt + 1'b1;
                    if (wing_last) begin
                        state_q <= rsmp_pkg::ST_PREP_LWING;
                    end
                end
                rsmp_pkg::ST_PREP_LWING: begin
                    wing_cnt <= '0;
                    state_q  <= rsmp_pkg::ST_LWING;
                end
                rsmp_pkg::ST_LWING: begin
                    wing_cnt <= wing_cnt + 1'b1;
                    if (wing_last) begin
                        state_q <= rsmp_pkg::ST_END;
                    end
                end
                rsmp_pkg::ST_END: begin
                    // Phase modulo NUM_PHASE, wrap goes with the pop
                    if (wrap) begin
                        phase_q <= rsmp_pkg::phase_t'(phase_sum - rsmp_pkg::NUM_PHASE);
                    end else begin
                        phase_q <= rsmp_pkg::phase_t'(phase_sum);
                    end
                    state_q <= rsmp_pkg::ST_READY;
                end
                default: state_q <= rsmp_pkg::ST_READY;
            endcase
        end
    end

    // Multiplier pipe and accumulator
    always_ff @(posedge clk) begin
        prod_pipe[0] <= $signed(rd_data_i) * $signed({1'b0, coef_i});
        for (int i = 1; i < rsmp_pkg::MULT_LATENCY; i++) begin
            prod_pipe[i] <= prod_pipe[i-1];
        end

        if (state_q == rsmp_pkg::ST_BEGIN) begin
            sum_q <= '0;
        end else if (product_valid) begin
            sum_q <= rsmp_pkg::result_t'($signed(sum_q) + prod_pipe[rsmp_pkg::MULT_LATENCY-1]);
        end
    end

endmodule

`default_nettype wire

// File: design/rsmp_pkg.sv
`default_nettype none

package rsmp_pkg;

    localparam int SAMPLE_W     = 16;
    localparam int COEF_W       = 8;
    localparam int RESULT_W     = 32;  // Exact for 8 taps of 16x8 bit products
    localparam int HALF_DEPTH   = 4;   // Taps per wing, window is twice this
    localparam int NUM_PHASE    = 8;
    localparam int PHASE_STEP   = 3;   // Phase advance per output
    localparam int MULT_LATENCY = 2;
    localparam int BUF_DEPTH    = 16;
    localparam int BUF_PTR_W    = $clog2(BUF_DEPTH);

    typedef logic [SAMPLE_W-1:0]               sample_t;
    typedef logic [COEF_W-1:0]                 coef_t;
    typedef logic [RESULT_W-1:0]               result_t;
    typedef logic [$clog2(NUM_PHASE)-1:0]      phase_t;
    typedef logic [$clog2(HALF_DEPTH)-1:0]     tap_t;
    typedef logic [$clog2(2*HALF_DEPTH)-1:0]   offset_t;
    typedef logic [$clog2(BUF_DEPTH):0]        count_t;  // Holds 0 to BUF_DEPTH
    typedef logic [BUF_PTR_W-1:0]              buf_ptr_t;

    typedef enum logic [2:0] {
        ST_READY,
        ST_BEGIN,
        ST_RWING,
        ST_PREP_LWING,
        ST_LWING,
        ST_END
    } mac_state_e;

    // Coefficient rule, (p+1)*(HALF_DEPTH-j)
    function automatic coef_t coef_value(input int unsigned p, input int unsigned j);
        return coef_t'((p + 1) * (HALF_DEPTH - j));
    endfunction

endpackage

`default_nettype wire

// File: design/rsmp_ring_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module rsmp_ring_buffer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wr_valid_i,
    input  wire rsmp_pkg::sample_t  wr_data_i,
    output logic                    wr_ready_o,
    input  wire                     pop_i,
    input  wire rsmp_pkg::offset_t  offset_i,
    output rsmp_pkg::sample_t       rd_data_o,
    output rsmp_pkg::count_t        count_o
);

    rsmp_pkg::sample_t  mem [rsmp_pkg::BUF_DEPTH];
    rsmp_pkg::buf_ptr_t wr_ptr;
    rsmp_pkg::buf_ptr_t rd_ptr;  // Oldest sample of the window
    rsmp_pkg::count_t   count;
    logic               push;

    assign wr_ready_o = (count != rsmp_pkg::count_t'(rsmp_pkg::BUF_DEPTH));
    assign push       = wr_valid_i && wr_ready_o;
    assign count_o    = count;

    // Pointers and fill level
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
        // Window read relative to read pointer, wraps around the store
        rd_data_o <= mem[rd_ptr + rsmp_pkg::buf_ptr_t'(offset_i)];
    end

endmodule

`default_nettype wire

// File: design/rsmp_top.sv
`timescale 1ns/1ps
`default_nettype none

module rsmp_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     sample_valid_i,
    input  wire rsmp_pkg::sample_t  sample_i,
    output logic                    sample_ready_o,
    input  wire                     wb_cyc_i,
    input  wire                     wb_stb_i,
    input  wire                     wb_we_i,
    input  wire                     wb_adr_i,
    output logic [31:0]             wb_dat_o,
    output logic                    wb_ack_o
);

    rsmp_pkg::count_t  buf_count;
    logic              buf_pop;
    rsmp_pkg::offset_t buf_offset;
    rsmp_pkg::sample_t buf_rd_data;
    rsmp_pkg::phase_t  rom_phase;
    rsmp_pkg::tap_t    rom_tap;
    rsmp_pkg::coef_t   rom_coef;
    logic              result_push;
    logic              result_full;
    rsmp_pkg::result_t result;

    rsmp_ring_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .wr_valid_i (sample_valid_i),
        .wr_data_i  (sample_i),
        .wr_ready_o (sample_ready_o),
        .pop_i      (buf_pop),
        .offset_i   (buf_offset),
        .rd_data_o  (buf_rd_data),
        .count_o    (buf_count)
    );

    rsmp_coef_rom u_rom (
        .clk     (clk),
        .phase_i (rom_phase),
        .tap_i   (rom_tap),
        .coef_o  (rom_coef)
    );

    rsmp_mac_core u_core (
        .clk           (clk),
        .rst           (rst),
        .count_i       (buf_count),
        .pop_o         (buf_pop),
        .offset_o      (buf_offset),
        .rd_data_i     (buf_rd_data),
        .phase_o       (rom_phase),
        .tap_o         (rom_tap),
        .coef_i        (rom_coef),
        .result_full_i (result_full),
        .result_push_o (result_push),
        .result_o      (result)
    );

    rsmp_wb_result u_result (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .push_i   (result_push),
        .result_i (result),
        .full_o   (result_full)
    );

endmodule

`default_nettype wire

// File: design/rsmp_wb_result.sv
`timescale 1ns/1ps
`default_nettype none

module rsmp_wb_result (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wb_cyc_i,
    input  wire                     wb_stb_i,
    input  wire                     wb_we_i,
    input  wire                     wb_adr_i,
    output logic [31:0]             wb_dat_o,
    output logic                    wb_ack_o,
    input  wire                     push_i,
    input  wire rsmp_pkg::result_t  result_i,
    output logic                    full_o
);

    rsmp_pkg::result_t result_q;
    logic              req;
    logic              rd_req;

    assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;  // New cycle, not yet answered
    assign rd_req = req && !wb_we_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            full_o   <= 1'b0;
        end else begin
            wb_ack_o <= req;
            if (push_i) begin
                full_o <= 1'b1;
            end else if (rd_req && !wb_adr_i) begin
                full_o <= 1'b0;  // Result taken by host
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            result_q <= result_i;
        end
        if (rd_req) begin
            wb_dat_o <= wb_adr_i ? {31'b0, full_o} : result_q;
        end
    end

endmodule

`default_nettype wire

// File: dv/rsmp_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rsmp_properties (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    wb_cyc_i,
    input  wire                    wb_stb_i,
    input  wire                    wb_ack_i,
    input  wire                    sample_ready_i,
    input  wire rsmp_pkg::count_t  buf_count_i,
    input  wire                    result_push_i,
    input  wire                    result_full_i
);

    int unsigned fail_count = 0;  // Failed assertions so far

    // Registered single-cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack_i |=> !wb_ack_i)
        else begin
            $error("wb_ack_o held longer than one cycle");
            fail_count++;
        end

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else begin
            $error("wb_ack_o outside a bus cycle");
            fail_count++;
        end

    // No room left in the ring buffer
    ready_when_full: assert property (@(posedge clk) disable iff (rst)
        (buf_count_i == rsmp_pkg::count_t'(rsmp_pkg::BUF_DEPTH)) |-> !sample_ready_i)
        else begin
            $error("sample_ready_o high with a full buffer");
            fail_count++;
        end

    push_while_full: assert property (@(posedge clk) disable iff (rst)
        result_full_i |-> !result_push_i)
        else begin
            $error("result pushed while the result port was full");
            fail_count++;
        end

endmodule

bind rsmp_top rsmp_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_ack_i       (wb_ack_o),
    .sample_ready_i (sample_ready_o),
    .buf_count_i    (buf_count),
    .result_push_i  (result_push),
    .result_full_i  (result_full)
);

`default_nettype wire

// File: dv/rsmp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rsmp_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_OUT    = 48;  // 40 streamed and 8 after the pause

    logic              clk;
    logic              rst;
    logic              sample_valid_i;
    rsmp_pkg::sample_t sample_i;
    logic              sample_ready_o;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic              wb_adr_i;
    logic [31:0]       wb_dat_o;
    logic              wb_ack_o;

    integer            seed = 65829;
    rsmp_pkg::sample_t sample_q [$];  // Accepted samples in arrival order
    rsmp_pkg::result_t got_q [$];
    int                model_phase = 0;
    int                n_in = 0;
    int                feed_limit = 0;
    int                n_checked = 0;
    int                value_errs = 0;
    int                other_errs = 0;

    rsmp_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Computation rule on the oldest 8 samples and then phase step and pop
    function automatic rsmp_pkg::result_t rsmp_expected();
        int acc;
        int p_left;
        acc = 0;
        p_left = rsmp_pkg::NUM_PHASE - 1 - model_phase;
        for (int j = 0; j < rsmp_pkg::HALF_DEPTH; j++) begin
            acc += $signed(sample_q[rsmp_pkg::HALF_DEPTH + j])
                   * int'(rsmp_pkg::coef_value(model_phase, j));
            acc += $signed(sample_q[rsmp_pkg::HALF_DEPTH - 1 - j])
                   * int'(rsmp_pkg::coef_value(p_left, j));
        end
        if (model_phase + rsmp_pkg::PHASE_STEP >= rsmp_pkg::NUM_PHASE) begin
            void'(sample_q.pop_front());
        end
        model_phase = (model_phase + rsmp_pkg::PHASE_STEP) % rsmp_pkg::NUM_PHASE;
        return rsmp_pkg::result_t'(acc);
    endfunction

    task automatic wb_access(input logic we, input logic adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        @(negedge clk);
        while (!wb_ack_o) @(negedge clk);
        data = wb_dat_o;
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    task automatic check_status(input logic [31:0] expected);
        logic [31:0] st;
        wb_access(1'b0, 1'b1, st);
        assert (st == expected) else begin
            value_errs++;
            $display("** Error at %0d ns: wb_dat_o status expected %h, got %h",
                     $time, expected, st);
        end
    endtask

    // Poll status and take the result, with optional writes first
    task automatic fetch_result(input logic poke);
        logic [31:0] st;
        logic [31:0] res;
        wb_access(1'b0, 1'b1, st);
        while (!st[0]) wb_access(1'b0, 1'b1, st);
        if (poke) begin
            wb_access(1'b1, 1'b0, st);
            wb_access(1'b1, 1'b1, st);
            check_status(32'd1);  // Writes leave the flag set
        end
        wb_access(1'b0, 1'b0, res);
        got_q.push_back(res);
        check_status(32'd0);
    endtask

    // Sample source keeps valid high while under the limit
    initial begin : feed_samples
        logic take;
        forever begin
            @(negedge clk);
            take = sample_valid_i && sample_ready_o;
            @(posedge clk);
            if (take) begin
                sample_q.push_back(sample_i);
                n_in++;
                sample_i <= rsmp_pkg::sample_t'($random(seed));
            end
            sample_valid_i <= (n_in < feed_limit);
        end
    end

    initial begin : compare_results
        rsmp_pkg::result_t expected;
        rsmp_pkg::result_t actual;
        forever begin
            @(negedge clk);
            while (got_q.size() > 0) begin
                actual   = got_q.pop_front();
                expected = rsmp_expected();
                assert (actual == expected) else begin
                    value_errs++;
                    $display("** Error at %0d ns: wb_dat_o expected %h, got %h",
                             $time, expected, actual);
                end
                n_checked++;
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (NUM_OUT * 40 + 200));
        $display("Timeout: the run did not finish in the allowed number of clock periods");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : run_tests
        logic seen_low;
        int   prop_errs;
        rst            = 1'b1;
        sample_valid_i = 1'b0;
        sample_i       = rsmp_pkg::sample_t'($random(seed));
        wb_cyc_i       = 1'b0;
        wb_stb_i       = 1'b0;
        wb_we_i        = 1'b0;
        wb_adr_i       = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (sample_ready_o === 1'b1) else begin
            value_errs++;
            $display("** Error at %0d ns: sample_ready_o expected 1, got %b",
                     $time, sample_ready_o);
        end
        check_status(32'd0);

        // Seven samples are not enough for a window
        feed_limit = rsmp_pkg::HALF_DEPTH * 2 - 1;
        while (n_in < feed_limit) @(negedge clk);
        repeat (30) @(negedge clk);
        check_status(32'd0);
        feed_limit = 1 << 30;

        for (int i = 0; i < 40; i++) begin
            fetch_result(i % 5 == 2);
        end

        // Host stalls while the input keeps offering
        seen_low = 1'b0;
        repeat (100) begin
            @(negedge clk);
            if (!sample_ready_o) seen_low = 1'b1;
        end
        assert (seen_low) else begin
            other_errs++;
            $display("sample_ready_o never fell while the host paused its reads");
        end
        for (int i = 0; i < NUM_OUT - 40; i++) begin
            fetch_result(1'b0);
        end

        while (n_checked < NUM_OUT) @(negedge clk);
        prop_errs = int'(uut.u_props.fail_count);
        $display("Checked %0d results: %0d value errors, %0d other errors, %0d assertion failures",
                 n_checked, value_errs, other_errs, prop_errs);
        if (value_errs == 0 && other_errs == 0 && prop_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
